//--- bench/tb_ppu.sv
`timescale 1ns/100ps

module tb_ppu;

	localparam int HS_TIMEOUT = 50;
	localparam int IDLE_POLLS = 2000;

	logic               clk_ppu;
	logic               rst_n_ppu;
	ppu_pkg::axil_req_t req;
	ppu_pkg::axil_rsp_t rsp;
	logic               lcd_cs;
	logic               lcd_dc;
	logic               lcd_sck;
	logic               lcd_mosi;

	// LCD capture state
	logic [15:0]        rx_q[$];
	logic [15:0]        rx_sh;
	int                 rx_bits;
	int                 word_bits;

	// Reference palette and scratch values
	logic [14:0]        pal_model [256];
	logic [7:0]         pal_used [16];
	logic [31:0]        rd;
	logic [15:0]        push_val [6];
	logic [14:0]        col;
	logic [7:0]         sel;
	logic               cs_bit;
	logic               dc_bit;
	int                 w;
	int                 h;
	int                 n_rx;

	ppu_top dut_i (
		.clk_ppu    (clk_ppu),
		.rst_n_ppu  (rst_n_ppu),
		.axil_req_i (req),
		.axil_rsp_o (rsp),
		.lcd_cs_o   (lcd_cs),
		.lcd_dc_o   (lcd_dc),
		.lcd_sck_o  (lcd_sck),
		.lcd_mosi_o (lcd_mosi)
	);

	always #20 clk_ppu = ~clk_ppu;

	// mosi is stable on each sck rise
	always @(posedge lcd_sck) begin
		rx_sh = {rx_sh[14:0], lcd_mosi};
		rx_bits++;
		if (rx_bits == word_bits) begin
			rx_q.push_back(word_bits == 16 ? rx_sh : {8'h00, rx_sh[7:0]});
			rx_bits = 0;
		end
	end

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out while waiting for %s", what);
		stop_run();
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// RGB555 to RGB565 with a zero as the new bit 5
	function automatic logic [15:0] rgb565(input logic [14:0] c);
		return {c[14:10], c[9:5], 1'b0, c[4:0]};
	endfunction

	// --------------------
	// AXI4-Lite access

	task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
		int cnt;
		@(negedge clk_ppu);
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		req.wstrb = 4'hf;
		#1;
		cnt = 0;
		while (!rsp.awready) begin
			if (cnt >= HS_TIMEOUT) begin
				timeout_fail("awready");
			end else begin
				@(negedge clk_ppu);
				#1;
				cnt++;
			end
		end
		check_eq(rsp.wready, 1'b1, "wready with awready");
		@(negedge clk_ppu);
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		req.bready = 1'b1;
		#1;
		cnt = 0;
		while (!rsp.bvalid) begin
			if (cnt >= HS_TIMEOUT) begin
				timeout_fail("bvalid");
			end else begin
				@(negedge clk_ppu);
				#1;
				cnt++;
			end
		end
		check_eq(rsp.bresp, 2'b00, "bresp");
		@(negedge clk_ppu);
		req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
		int cnt;
		@(negedge clk_ppu);
		req.arvalid = 1'b1;
		req.araddr = addr;
		#1;
		cnt = 0;
		while (!rsp.arready) begin
			if (cnt >= HS_TIMEOUT) begin
				timeout_fail("arready");
			end else begin
				@(negedge clk_ppu);
				#1;
				cnt++;
			end
		end
		@(negedge clk_ppu);
		req.arvalid = 1'b0;
		req.rready = 1'b1;
		#1;
		cnt = 0;
		while (!rsp.rvalid) begin
			if (cnt >= HS_TIMEOUT) begin
				timeout_fail("rvalid");
			end else begin
				@(negedge clk_ppu);
				#1;
				cnt++;
			end
		end
		data = rsp.rdata;
		check_eq(rsp.rresp, 2'b00, "rresp");
		@(negedge clk_ppu);
		req.rready = 1'b0;
	endtask

	// --------------------
	// LCD helpers

	task automatic clear_capture();
		rx_q.delete();
		rx_bits = 0;
	endtask

	task automatic wait_words(input int n);
		int cnt;
		cnt = 0;
		while (rx_q.size() < n) begin
			if (cnt >= n * 40 + 200) begin
				timeout_fail("words on the LCD output");
			end else begin
				@(negedge clk_ppu);
				cnt++;
			end
		end
	endtask

	// Two idle reads in a row so that a pixel in flight is not missed
	task automatic wait_lcd_idle();
		logic [31:0] st;
		int quiet;
		int cnt;
		quiet = 0;
		cnt = 0;
		while (quiet < 2) begin
			if (cnt >= IDLE_POLLS) begin
				timeout_fail("the LCD shifter to go idle");
			end else begin
				axil_read(ppu_pkg::REG_LCD_CSR, st);
				quiet = (!st[8] && st[9]) ? quiet + 1 : 0;
				cnt++;
			end
		end
	endtask

	task automatic run_frame(input int fw, input int fh, input logic [31:0] bg,
		input logic [31:0] csr);
		axil_write(ppu_pkg::REG_DISPSIZE, ((fh - 1) << 16) | (fw - 1));
		axil_write(ppu_pkg::REG_DEFAULT_BG, bg);
		clear_capture();
		axil_write(ppu_pkg::REG_CSR, csr);
	endtask

	task automatic check_frame(input int n, input logic [15:0] exp);
		wait_words(n);
		wait_lcd_idle();
		check_eq(rx_q.size(), n, "LCD word count");
		foreach (rx_q[i]) begin
			check_eq(rx_q[i], exp, "LCD frame word");
		end
	endtask

	initial begin
		clk_ppu = 1'b0;
		rst_n_ppu = 1'b0;
		req = '0;
		rx_sh = '0;
		rx_bits = 0;
		word_bits = 16;
		void'($urandom(13410));
		repeat (4) @(negedge clk_ppu);
		rst_n_ppu = 1'b1;

		// Reset values and register readback
		axil_read(ppu_pkg::REG_CSR, rd);
		check_eq(rd & 32'h10, 32'h0, "CSR running after reset");
		axil_read(ppu_pkg::REG_LCD_CSR, rd);
		check_eq(rd & 32'h703, 32'h201, "LCD_CSR after reset");
		repeat (4) begin
			w = $urandom & 32'h01ff01ff;
			axil_write(ppu_pkg::REG_DISPSIZE, w);
			axil_read(ppu_pkg::REG_DISPSIZE, rd);
			check_eq(rd, w, "DISPSIZE readback");
			w = $urandom & 32'hffff;
			axil_write(ppu_pkg::REG_DEFAULT_BG, w);
			axil_read(ppu_pkg::REG_DEFAULT_BG, rd);
			check_eq(rd, w, "DEFAULT_BG readback");
			w = $urandom & 32'hc;
			axil_write(ppu_pkg::REG_CSR, w);
			axil_read(ppu_pkg::REG_CSR, rd);
			check_eq(rd & 32'hc, w, "CSR halt bits");
			cs_bit = $urandom;
			dc_bit = $urandom;
			axil_write(ppu_pkg::REG_LCD_CSR, {29'b0, 1'b1, dc_bit, cs_bit});
			axil_read(ppu_pkg::REG_LCD_CSR, rd);
			check_eq(rd & 32'h7, {29'b0, 1'b1, dc_bit, cs_bit}, "LCD_CSR config");
			check_eq(lcd_cs, cs_bit, "lcd_cs pin");
			check_eq(lcd_dc, dc_bit, "lcd_dc pin");
		end
		axil_write(ppu_pkg::REG_CSR, 32'h0);

		// Direct pushes as full words and then as low bytes
		axil_write(ppu_pkg::REG_LCD_CSR, 32'h5);
		clear_capture();
		foreach (push_val[i]) begin
			push_val[i] = $urandom;
			axil_write(ppu_pkg::REG_LCD_PXFIFO, {16'h0, push_val[i]});
		end
		wait_words(6);
		wait_lcd_idle();
		check_eq(rx_q.size(), 6, "direct word count");
		foreach (push_val[i]) begin
			check_eq(rx_q[i], push_val[i], "direct 16-bit word");
		end
		word_bits = 8;
		axil_write(ppu_pkg::REG_LCD_CSR, 32'h1);
		clear_capture();
		foreach (push_val[i]) begin
			push_val[i] = $urandom;
			axil_write(ppu_pkg::REG_LCD_PXFIFO, {16'h0, push_val[i]});
		end
		wait_words(6);
		wait_lcd_idle();
		check_eq(rx_q.size(), 6, "direct byte count");
		foreach (push_val[i]) begin
			check_eq(rx_q[i], {8'h00, push_val[i][7:0]}, "direct byte");
		end
		word_bits = 16;
		axil_write(ppu_pkg::REG_LCD_CSR, 32'h5);

		// Direct colour frame that stops at end of frame
		w = $urandom_range(11, 4);
		h = $urandom_range(6, 3);
		col = $urandom;
		run_frame(w, h, {17'b0, col}, 32'h9);
		check_frame(w * h, rgb565(col));
		axil_read(ppu_pkg::REG_CSR, rd);
		check_eq(rd & 32'h10, 32'h0, "running after frame");
		axil_read(ppu_pkg::REG_BEAM, rd);
		check_eq(rd, 32'h0, "BEAM after frame");

		// Paletted frame
		foreach (pal_used[i]) begin
			pal_used[i] = $urandom;
			col = $urandom;
			pal_model[pal_used[i]] = col;
			axil_write(16'h0800 + {6'b0, pal_used[i], 2'b00}, {17'b0, col});
		end
		sel = pal_used[$urandom_range(15, 0)];
		w = $urandom_range(11, 4);
		h = $urandom_range(6, 3);
		run_frame(w, h, {16'b0, 1'b1, 7'($urandom), sel}, 32'h9);
		check_frame(w * h, rgb565(pal_model[sel]));
		axil_read(ppu_pkg::REG_BEAM, rd);
		check_eq(rd, 32'h0, "BEAM after paletted frame");

		// One row with halt_hsync
		w = $urandom_range(11, 4);
		h = $urandom_range(6, 2);
		col = $urandom;
		run_frame(w, h, {17'b0, col}, 32'h5);
		check_frame(w, rgb565(col));
		axil_read(ppu_pkg::REG_BEAM, rd);
		check_eq(rd, 32'h0001_0000, "BEAM after row");
		axil_read(ppu_pkg::REG_CSR, rd);
		check_eq(rd & 32'h10, 32'h0, "running after row");

		// Halt strobe in the middle of a large frame
		col = $urandom;
		run_frame(64, 64, {17'b0, col}, 32'h1);
		wait_words(10);
		axil_write(ppu_pkg::REG_CSR, 32'h2);
		axil_read(ppu_pkg::REG_CSR, rd);
		check_eq(rd & 32'h10, 32'h0, "running after halt strobe");
		wait_lcd_idle();
		n_rx = rx_q.size();
		repeat (200) @(negedge clk_ppu);
		check_eq(rx_q.size(), n_rx, "word count after halt");
		check_eq(n_rx <= 64 * 64, 1'b1, "word count within frame");
		foreach (rx_q[i]) begin
			check_eq(rx_q[i], rgb565(col), "word before halt");
		end

		$display("Test OK");
		$finish;
	end

endmodule

//--- build.f
logic/ppu_pkg.sv
logic/ppu_regs.sv
logic/ppu_raster.sv
logic/ppu_palette_map.sv
logic/ppu_pixel_fifo.sv
logic/ppu_lcd_shifter.sv
logic/ppu_top.sv
bench/tb_ppu.sv

//--- logic/ppu_lcd_shifter.sv
`timescale 1ns/100ps

module ppu_lcd_shifter (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  logic                              empty_i,
	input  logic [ppu_pkg::LCD_PIXDATA_W-1:0] rdata_i,
	output logic                              pop_o,
	input  logic                              shift16_i,
	output logic                              busy_o,
	output logic                              lcd_sck_o,
	output logic                              lcd_mosi_o
);

	logic                              busy_q;
	logic                              sck_q;
	logic [ppu_pkg::LCD_PIXDATA_W-1:0] shreg_q;
	logic [3:0]                        bits_left_q;

	assign pop_o = !busy_q && !empty_i;

	// Each bit is one low cycle then one high cycle
	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			busy_q <= 1'b0;
			sck_q <= 1'b0;
			shreg_q <= '0;
			bits_left_q <= '0;
		end else if (pop_o) begin
			busy_q <= 1'b1;
			sck_q <= 1'b0;
			// Byte mode sends the low byte, left aligned for MSB first
			shreg_q <= shift16_i ? rdata_i : {rdata_i[7:0], 8'h00};
			bits_left_q <= shift16_i ? 4'd15 : 4'd7;
		end else if (busy_q) begin
			if (!sck_q) begin
				sck_q <= 1'b1;
			end else begin
				sck_q <= 1'b0;
				if (bits_left_q == 4'd0) begin
					busy_q <= 1'b0;
				end else begin
					bits_left_q <= bits_left_q - 1'b1;
					shreg_q <= {shreg_q[ppu_pkg::LCD_PIXDATA_W-2:0], 1'b0};
				end
			end
		end
	end

	// Data moves only on the falling sck edge
	assign lcd_mosi_o = shreg_q[ppu_pkg::LCD_PIXDATA_W-1];
	assign lcd_sck_o = sck_q;
	assign busy_o = busy_q || pop_o;

endmodule

//--- logic/ppu_palette_map.sv
`timescale 1ns/100ps

module ppu_palette_map (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  ppu_pkg::pram_wr_t                 pram_wr_i,
	input  logic                              in_valid_i,
	output logic                              in_ready_o,
	input  ppu_pkg::ppu_px_t                  in_px_i,
	output logic                              out_valid_o,
	input  logic                              out_ready_i,
	output logic [ppu_pkg::LCD_PIXDATA_W-1:0] out_data_o
);

	logic [ppu_pkg::PIXDATA_W-1:0]     pram [2**ppu_pkg::PALETTE_IDX_W];
	ppu_pkg::ppu_pixel_t               colour;
	logic                              in_fire;
	logic                              out_valid_q;
	logic [ppu_pkg::LCD_PIXDATA_W-1:0] out_data_q;

	// Palette RAM, written from the bus only
	always_ff @(posedge clk_ppu) begin
		if (pram_wr_i.en) begin
			pram[pram_wr_i.idx] <= pram_wr_i.data;
		end
	end

	always_comb begin
		if (in_px_i.paletted) begin
			colour = ppu_pkg::ppu_pixel_t'(pram[in_px_i.pixel.pal.idx]);
		end else begin
			colour = in_px_i.pixel;
		end
	end

	assign in_ready_o = !out_valid_q || out_ready_i;
	assign in_fire = in_valid_i && in_ready_o;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			out_valid_q <= 1'b0;
		end else if (in_fire) begin
			out_valid_q <= 1'b1;
		end else if (out_ready_i) begin
			out_valid_q <= 1'b0;
		end
	end

	// RGB555 to RGB565, new green LSB is zero
	always_ff @(posedge clk_ppu) begin
		if (in_fire) begin
			out_data_q <= {colour.rgb.r, colour.rgb.g, 1'b0, colour.rgb.b};
		end
	end

	assign out_valid_o = out_valid_q;
	assign out_data_o = out_data_q;

endmodule

//--- logic/ppu_pixel_fifo.sv
`timescale 1ns/100ps

module ppu_pixel_fifo (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  logic                              direct_push_i,
	input  logic [ppu_pkg::LCD_PIXDATA_W-1:0] direct_data_i,
	input  logic                              px_valid_i,
	output logic                              px_ready_o,
	input  logic [ppu_pkg::LCD_PIXDATA_W-1:0] px_data_i,
	input  logic                              pop_i,
	output logic [ppu_pkg::LCD_PIXDATA_W-1:0] rdata_o,
	output logic                              empty_o,
	output logic                              full_o
);

	logic [ppu_pkg::LCD_PIXDATA_W-1:0] mem [ppu_pkg::PXFIFO_DEPTH];
	// Extra top bit tells full from empty
	logic [ppu_pkg::PXFIFO_PTR_W:0]    wr_ptr_q;
	logic [ppu_pkg::PXFIFO_PTR_W:0]    rd_ptr_q;
	logic                              push;
	logic [ppu_pkg::LCD_PIXDATA_W-1:0] wdata;

	assign empty_o = wr_ptr_q == rd_ptr_q;
	assign full_o = (wr_ptr_q[ppu_pkg::PXFIFO_PTR_W] != rd_ptr_q[ppu_pkg::PXFIFO_PTR_W]) &&
		(wr_ptr_q[ppu_pkg::PXFIFO_PTR_W-1:0] == rd_ptr_q[ppu_pkg::PXFIFO_PTR_W-1:0]);

	// Software pushes win the write port
	assign px_ready_o = !full_o && !direct_push_i;
	assign push = (direct_push_i && !full_o) || (px_valid_i && px_ready_o);
	assign wdata = direct_push_i ? direct_data_i : px_data_i;

	always_ff @(posedge clk_ppu) begin
		if (push) begin
			mem[wr_ptr_q[ppu_pkg::PXFIFO_PTR_W-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i && !empty_o) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	assign rdata_o = mem[rd_ptr_q[ppu_pkg::PXFIFO_PTR_W-1:0]];

endmodule

//--- logic/ppu_pkg.sv
package ppu_pkg;

	// Sizes
	localparam int SCREEN_COORD_W = 9;
	localparam int PIXDATA_W = 15;
	localparam int LCD_PIXDATA_W = 16;
	localparam int PALETTE_IDX_W = 8;
	localparam int PXFIFO_DEPTH = 8;
	localparam int PXFIFO_PTR_W = $clog2(PXFIFO_DEPTH);
	localparam int AXIL_ADDR_W = 16;
	localparam int AXIL_DATA_W = 32;

	// Register byte offsets
	localparam logic [AXIL_ADDR_W-1:0] REG_CSR = 16'h0000;
	localparam logic [AXIL_ADDR_W-1:0] REG_DISPSIZE = 16'h0004;
	localparam logic [AXIL_ADDR_W-1:0] REG_BEAM = 16'h0008;
	localparam logic [AXIL_ADDR_W-1:0] REG_DEFAULT_BG = 16'h000c;
	localparam logic [AXIL_ADDR_W-1:0] REG_LCD_CSR = 16'h0010;
	localparam logic [AXIL_ADDR_W-1:0] REG_LCD_PXFIFO = 16'h0014;
	// Palette window, 256 word entries
	localparam logic [AXIL_ADDR_W-1:0] PRAM_BASE = 16'h0800;

	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} ppu_rgb_t;

	typedef struct packed {
		logic [PIXDATA_W-PALETTE_IDX_W-1:0] pad;
		logic [PALETTE_IDX_W-1:0]           idx;
	} ppu_pal_t;

	// Same 15 bits seen either as a colour or as a palette index
	typedef union packed {
		ppu_rgb_t rgb;
		ppu_pal_t pal;
	} ppu_pixel_t;

	typedef struct packed {
		ppu_pixel_t pixel;
		logic       paletted;
	} ppu_px_t;

	typedef struct packed {
		logic                     en;
		logic [PALETTE_IDX_W-1:0] idx;
		logic [PIXDATA_W-1:0]     data;
	} pram_wr_t;

	typedef struct packed {
		logic [SCREEN_COORD_W-1:0] width;
		logic [SCREEN_COORD_W-1:0] height;
		logic                      run;
		logic                      halt;
		logic                      halt_hsync;
		logic                      halt_vsync;
	} raster_cfg_t;

	typedef struct packed {
		logic cs;
		logic dc;
		logic shift16;
	} lcd_cfg_t;

	typedef struct packed {
		logic                     awvalid;
		logic [AXIL_ADDR_W-1:0]   awaddr;
		logic                     wvalid;
		logic [AXIL_DATA_W-1:0]   wdata;
		logic [AXIL_DATA_W/8-1:0] wstrb;
		logic                     bready;
		logic                     arvalid;
		logic [AXIL_ADDR_W-1:0]   araddr;
		logic                     rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   bvalid;
		logic [1:0]             bresp;
		logic                   arready;
		logic                   rvalid;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [1:0]             rresp;
	} axil_rsp_t;

endpackage

//--- logic/ppu_raster.sv
`timescale 1ns/100ps

module ppu_raster (
	input  logic                               clk_ppu,
	input  logic                               rst_n_ppu,
	input  ppu_pkg::raster_cfg_t               raster_cfg_i,
	input  ppu_pkg::ppu_px_t                   default_px_i,
	output logic                               px_valid_o,
	input  logic                               px_ready_i,
	output ppu_pkg::ppu_px_t                   px_o,
	output logic                               running_o,
	output logic [ppu_pkg::SCREEN_COORD_W-1:0] beam_x_o,
	output logic [ppu_pkg::SCREEN_COORD_W-1:0] beam_y_o
);

	logic                               running_q;
	logic [ppu_pkg::SCREEN_COORD_W-1:0] x_q;
	logic [ppu_pkg::SCREEN_COORD_W-1:0] y_q;
	logic                               fire;
	logic                               end_row;
	logic                               end_frame;
	logic                               sync_halt;

	assign fire = running_q && px_ready_i;
	assign end_row = x_q == raster_cfg_i.width;
	assign end_frame = end_row && (y_q == raster_cfg_i.height);

	// Stop after the pixel that closes a row or frame
	assign sync_halt = fire && ((end_row && raster_cfg_i.halt_hsync) ||
		(end_frame && raster_cfg_i.halt_vsync));

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_q <= '0;
			y_q <= '0;
		end else if (fire) begin
			if (end_row) begin
				x_q <= '0;
				y_q <= end_frame ? '0 : y_q + 1'b1;
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			running_q <= 1'b0;
		end else if (raster_cfg_i.halt || sync_halt) begin
			running_q <= 1'b0;
		end else if (raster_cfg_i.run) begin
			running_q <= 1'b1;
		end
	end

	// Only the default colour exists as a pixel source
	assign px_valid_o = running_q;
	assign px_o = default_px_i;
	assign running_o = running_q;
	assign beam_x_o = x_q;
	assign beam_y_o = y_q;

endmodule

//--- logic/ppu_regs.sv
`timescale 1ns/100ps

module ppu_regs (
	input  logic                                    clk_ppu,
	input  logic                                    rst_n_ppu,

	input  ppu_pkg::axil_req_t                      axil_req_i,
	output ppu_pkg::axil_rsp_t                      axil_rsp_o,

	output ppu_pkg::raster_cfg_t                    raster_cfg_o,
	output ppu_pkg::ppu_px_t                        default_px_o,
	input  logic                                    running_i,
	input  logic [ppu_pkg::SCREEN_COORD_W-1:0]      beam_x_i,
	input  logic [ppu_pkg::SCREEN_COORD_W-1:0]      beam_y_i,

	output ppu_pkg::pram_wr_t                       pram_wr_o,

	output logic                                    direct_push_o,
	output logic [ppu_pkg::LCD_PIXDATA_W-1:0]       direct_data_o,
	input  logic                                    fifo_empty_i,
	input  logic                                    fifo_full_i,

	output ppu_pkg::lcd_cfg_t                       lcd_cfg_o,
	input  logic                                    lcd_busy_i
);

	logic                                  aw_hs;
	logic                                  ar_hs;
	logic                                  bvalid_q;
	logic                                  rvalid_q;
	logic [ppu_pkg::AXIL_DATA_W-1:0]       rdata_q;
	logic [ppu_pkg::AXIL_DATA_W-1:0]       wr_old;
	logic [ppu_pkg::AXIL_DATA_W-1:0]       wr_mask;
	logic [ppu_pkg::AXIL_DATA_W-1:0]       wr_word;
	logic                                  pram_hit;

	logic                                  halt_hsync_q;
	logic                                  halt_vsync_q;
	logic [ppu_pkg::SCREEN_COORD_W-1:0]    disp_w_q;
	logic [ppu_pkg::SCREEN_COORD_W-1:0]    disp_h_q;
	ppu_pkg::ppu_px_t                      default_px_q;
	ppu_pkg::lcd_cfg_t                     lcd_cfg_q;

	// Register image as seen by a read
	function automatic logic [ppu_pkg::AXIL_DATA_W-1:0] reg_word(
		input logic [ppu_pkg::AXIL_ADDR_W-1:0] addr
	);
		case (addr)
			ppu_pkg::REG_CSR:
				reg_word = {27'b0, running_i, halt_vsync_q, halt_hsync_q, 2'b0};
			ppu_pkg::REG_DISPSIZE:
				reg_word = {7'b0, disp_h_q, 7'b0, disp_w_q};
			ppu_pkg::REG_BEAM:
				reg_word = {7'b0, beam_y_i, 7'b0, beam_x_i};
			ppu_pkg::REG_DEFAULT_BG:
				reg_word = {16'b0, default_px_q.paletted, default_px_q.pixel};
			ppu_pkg::REG_LCD_CSR:
				reg_word = {21'b0, fifo_full_i, fifo_empty_i, lcd_busy_i, 5'b0,
					lcd_cfg_q.shift16, lcd_cfg_q.dc, lcd_cfg_q.cs};
			default:
				reg_word = '0;
		endcase
	endfunction

	// --------------------
	// Write channel

	assign aw_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			bvalid_q <= 1'b0;
		end else if (aw_hs) begin
			bvalid_q <= 1'b1;
		end else if (axil_req_i.bready) begin
			bvalid_q <= 1'b0;
		end
	end

	// Byte lanes merged over the current value
	always_comb begin
		for (int i = 0; i < ppu_pkg::AXIL_DATA_W / 8; i++) begin
			wr_mask[8*i +: 8] = {8{axil_req_i.wstrb[i]}};
		end
		wr_old = reg_word(axil_req_i.awaddr);
		wr_word = (wr_old & ~wr_mask) | (axil_req_i.wdata & wr_mask);
	end

	assign pram_hit = axil_req_i.awaddr[15:10] == ppu_pkg::PRAM_BASE[15:10];

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			halt_hsync_q <= 1'b0;
			halt_vsync_q <= 1'b0;
			disp_w_q <= '0;
			disp_h_q <= '0;
			default_px_q <= '0;
			lcd_cfg_q <= '{cs: 1'b1, dc: 1'b0, shift16: 1'b0};
		end else if (aw_hs) begin
			case (axil_req_i.awaddr)
				ppu_pkg::REG_CSR: begin
					halt_hsync_q <= wr_word[2];
					halt_vsync_q <= wr_word[3];
				end
				ppu_pkg::REG_DISPSIZE: begin
					disp_w_q <= wr_word[8:0];
					disp_h_q <= wr_word[24:16];
				end
				ppu_pkg::REG_DEFAULT_BG: begin
					default_px_q.pixel <= wr_word[14:0];
					default_px_q.paletted <= wr_word[15];
				end
				ppu_pkg::REG_LCD_CSR: begin
					lcd_cfg_q.cs <= wr_word[0];
					lcd_cfg_q.dc <= wr_word[1];
					lcd_cfg_q.shift16 <= wr_word[2];
				end
				default: begin
				end
			endcase
		end
	end

	// One-cycle strobes straight from the write handshake
	assign raster_cfg_o = '{
		width:      disp_w_q,
		height:     disp_h_q,
		run:        aw_hs && axil_req_i.awaddr == ppu_pkg::REG_CSR && wr_word[0],
		halt:       aw_hs && axil_req_i.awaddr == ppu_pkg::REG_CSR && wr_word[1],
		halt_hsync: halt_hsync_q,
		halt_vsync: halt_vsync_q
	};

	assign pram_wr_o = '{
		en:   aw_hs && pram_hit,
		idx:  axil_req_i.awaddr[ppu_pkg::PALETTE_IDX_W+1:2],
		data: wr_word[ppu_pkg::PIXDATA_W-1:0]
	};

	assign direct_push_o = aw_hs && axil_req_i.awaddr == ppu_pkg::REG_LCD_PXFIFO;
	assign direct_data_o = wr_word[ppu_pkg::LCD_PIXDATA_W-1:0];
	assign default_px_o = default_px_q;
	assign lcd_cfg_o = lcd_cfg_q;

	// --------------------
	// Read channel

	assign ar_hs = axil_req_i.arvalid && !rvalid_q;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			rvalid_q <= 1'b0;
		end else if (ar_hs) begin
			rvalid_q <= 1'b1;
		end else if (axil_req_i.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_ppu) begin
		if (ar_hs) begin
			rdata_q <= reg_word(axil_req_i.araddr);
		end
	end

	assign axil_rsp_o = '{
		awready: aw_hs,
		wready:  aw_hs,
		bvalid:  bvalid_q,
		bresp:   2'b00,
		arready: !rvalid_q,
		rvalid:  rvalid_q,
		rdata:   rdata_q,
		rresp:   2'b00
	};

endmodule

//--- logic/ppu_top.sv
`timescale 1ns/100ps

module ppu_top (
	input  logic               clk_ppu,
	input  logic               rst_n_ppu,
	input  ppu_pkg::axil_req_t axil_req_i,
	output ppu_pkg::axil_rsp_t axil_rsp_o,
	output logic               lcd_cs_o,
	output logic               lcd_dc_o,
	output logic               lcd_sck_o,
	output logic               lcd_mosi_o
);

	ppu_pkg::raster_cfg_t               raster_cfg;
	ppu_pkg::ppu_px_t                   default_px;
	ppu_pkg::pram_wr_t                  pram_wr;
	ppu_pkg::lcd_cfg_t                  lcd_cfg;
	ppu_pkg::ppu_px_t                   raster_px;
	logic                               running;
	logic [ppu_pkg::SCREEN_COORD_W-1:0] beam_x;
	logic [ppu_pkg::SCREEN_COORD_W-1:0] beam_y;
	logic                               raster_valid;
	logic                               raster_ready;
	logic                               pmap_valid;
	logic                               pmap_ready;
	logic [ppu_pkg::LCD_PIXDATA_W-1:0]  pmap_data;
	logic                               direct_push;
	logic [ppu_pkg::LCD_PIXDATA_W-1:0]  direct_data;
	logic                               fifo_pop;
	logic [ppu_pkg::LCD_PIXDATA_W-1:0]  fifo_rdata;
	logic                               fifo_empty;
	logic                               fifo_full;
	logic                               lcd_busy;

	// --------------------
	// Configuration

	ppu_regs regs_i (
		.clk_ppu       (clk_ppu),
		.rst_n_ppu     (rst_n_ppu),
		.axil_req_i    (axil_req_i),
		.axil_rsp_o    (axil_rsp_o),
		.raster_cfg_o  (raster_cfg),
		.default_px_o  (default_px),
		.running_i     (running),
		.beam_x_i      (beam_x),
		.beam_y_i      (beam_y),
		.pram_wr_o     (pram_wr),
		.direct_push_o (direct_push),
		.direct_data_o (direct_data),
		.fifo_empty_i  (fifo_empty),
		.fifo_full_i   (fifo_full),
		.lcd_cfg_o     (lcd_cfg),
		.lcd_busy_i    (lcd_busy)
	);

	// --------------------
	// Pixel path

	ppu_raster raster_i (
		.clk_ppu      (clk_ppu),
		.rst_n_ppu    (rst_n_ppu),
		.raster_cfg_i (raster_cfg),
		.default_px_i (default_px),
		.px_valid_o   (raster_valid),
		.px_ready_i   (raster_ready),
		.px_o         (raster_px),
		.running_o    (running),
		.beam_x_o     (beam_x),
		.beam_y_o     (beam_y)
	);

	ppu_palette_map palette_map_i (
		.clk_ppu     (clk_ppu),
		.rst_n_ppu   (rst_n_ppu),
		.pram_wr_i   (pram_wr),
		.in_valid_i  (raster_valid),
		.in_ready_o  (raster_ready),
		.in_px_i     (raster_px),
		.out_valid_o (pmap_valid),
		.out_ready_i (pmap_ready),
		.out_data_o  (pmap_data)
	);

	ppu_pixel_fifo pixel_fifo_i (
		.clk_ppu       (clk_ppu),
		.rst_n_ppu     (rst_n_ppu),
		.direct_push_i (direct_push),
		.direct_data_i (direct_data),
		.px_valid_i    (pmap_valid),
		.px_ready_o    (pmap_ready),
		.px_data_i     (pmap_data),
		.pop_i         (fifo_pop),
		.rdata_o       (fifo_rdata),
		.empty_o       (fifo_empty),
		.full_o        (fifo_full)
	);

	// --------------------
	// LCD output

	ppu_lcd_shifter lcd_shifter_i (
		.clk_ppu    (clk_ppu),
		.rst_n_ppu  (rst_n_ppu),
		.empty_i    (fifo_empty),
		.rdata_i    (fifo_rdata),
		.pop_o      (fifo_pop),
		.shift16_i  (lcd_cfg.shift16),
		.busy_o     (lcd_busy),
		.lcd_sck_o  (lcd_sck_o),
		.lcd_mosi_o (lcd_mosi_o)
	);

	assign lcd_cs_o = lcd_cfg.cs;
	assign lcd_dc_o = lcd_cfg.dc;

endmodule
